//--- Makefile
# Verilator build and run for the gshare predictor testbench

VERILATOR ?= verilator
TOP ?= gshareTb
SEED ?= 1
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: run build lint clean

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sources.f
+incdir+verilog
verilog/gsharePkg.sv
verilog/phtBankedRam.sv
verilog/phtWriteQueue.sv
verilog/gshareFetchPredict.sv
verilog/phtUpdateArbiter.sv
verilog/gshareUnit.sv
tb/gshareRefModel.sv
tb/gshareTb.sv

//--- tb/gshareRefModel.sv
/*
 * gshare reference model
 * Index hash, history shift and saturating counters, plus a shadow copy
 * of the counter table that the testbench trains alongside the DUT
 */
`include "gshare_macros.svh"

module gshareRefModel;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TABLE_SIZE = 1 << `GS_PHT_INDEX_BITS;

    gsharePkg::phtCounterT modelCounter [TABLE_SIZE];

    // The reset fill leaves every entry weakly taken
    initial begin
        for (int i = 0; i < TABLE_SIZE; i++) begin
            modelCounter[i] = gsharePkg::phtCounterT'(`GS_COUNTER_INIT);
        end
    end

    function automatic gsharePkg::phtIndexT hashIndex(gsharePkg::addrT pc,
                                                      gsharePkg::globalHistoryT hist);
        gsharePkg::phtIndexT addrBits;
        gsharePkg::phtIndexT histMask;
        addrBits = gsharePkg::phtIndexT'(pc >> `GS_INSN_OFFSET_BITS);
        histMask = '0;
        // Newest outcome lands on the top index bit
        for (int i = 0; i < `GS_HISTORY_BITS; i++) begin
            histMask[`GS_PHT_INDEX_BITS - 1 - i] = hist[i];
        end
        return addrBits ^ histMask;
    endfunction

    function automatic gsharePkg::globalHistoryT shiftHistory(gsharePkg::globalHistoryT hist,
                                                              logic taken);
        return {hist[`GS_HISTORY_BITS-2:0], taken};
    endfunction

    function automatic gsharePkg::phtCounterT nextCounter(gsharePkg::phtCounterT cnt,
                                                          logic taken);
        gsharePkg::phtCounterT result;
        result = cnt;
        if (taken && cnt != gsharePkg::phtCounterT'(`GS_COUNTER_MAX)) begin
            result = cnt + 1'b1;
        end else if (!taken && cnt != '0) begin
            result = cnt - 1'b1;
        end
        return result;
    endfunction

    function automatic gsharePkg::phtCounterT counterAt(gsharePkg::phtIndexT idx);
        return modelCounter[idx];
    endfunction

    task automatic recordResult(gsharePkg::phtIndexT idx, logic taken);
        modelCounter[idx] = nextCounter(modelCounter[idx], taken);
    endtask

endmodule

//--- tb/gshareTb.sv
/*
 * gshare predictor testbench
 * Drives fetch and execute traffic into the unit and checks predictions,
 * indices, counters and history against the reference model
 */
`include "gshare_macros.svh"

module gshareTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FW = `GS_FETCH_WIDTH;
    localparam int IW = `GS_ISSUE_WIDTH;
    localparam int TABLE_SIZE = 1 << `GS_PHT_INDEX_BITS;
    localparam int FILL_CYCLES = TABLE_SIZE / IW;
    localparam int IDLE_WAIT = 8;
    localparam int SAT_STEPS = (1 << `GS_COUNTER_BITS) + 1;
    // Reset, fill, two table sweeps and the random phases stay well below this
    localparam int TIMEOUT_CYCLES = 3000;

    logic clk;
    logic rstN;
    gsharePkg::addrT predPc;
    logic [FW-1:0] btbHit;
    logic [FW-1:0] isCondBr;
    logic [FW-1:0] historyValid;
    logic [FW-1:0] predTaken;
    gsharePkg::phtIndexT phtIndex [FW];
    gsharePkg::phtCounterT phtPrevValue [FW];
    gsharePkg::globalHistoryT brHistory [FW];
    logic [IW-1:0] resultValid;
    logic [IW-1:0] resultIsUncond;
    logic [IW-1:0] resultTaken;
    logic [IW-1:0] resultMispred;
    gsharePkg::phtIndexT resultPhtIndex [IW];
    gsharePkg::phtCounterT resultPrevCounter [IW];
    logic recoverHistory;
    gsharePkg::globalHistoryT recoveredHistory;
    logic fillBusy;

    // Expected outputs for the cycle in progress
    logic checkOn;
    logic [FW-1:0] expTaken;
    gsharePkg::phtIndexT expIndex [FW];
    gsharePkg::phtCounterT expPrev [FW];
    gsharePkg::globalHistoryT expHist [FW];

    // Model of the history register and the fetch one cycle back
    gsharePkg::globalHistoryT modelHist;
    gsharePkg::addrT lastPc;
    logic mispredLast;

    int cycleCount = 0;
    int fillCycles = 0;
    logic fillDone = 1'b0;

    gshareUnit dut0 (.*);

    gshareRefModel refModel0 ();

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopOnError(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (rstN && fillBusy) begin
            fillCycles <= fillCycles + 1;
        end
        if (rstN && !fillBusy) begin
            fillDone <= 1'b1;
        end
        if (cycleCount >= TIMEOUT_CYCLES) begin
            stopOnError($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (!fillBusy && !fillDone) |-> fillCycles == FILL_CYCLES)
        else stopOnError($sformatf("FAIL t=%0t fillBusy cycles exp=%0d got=%0d",
            $time, FILL_CYCLES, $sampled(fillCycles)));

    assert property (@(posedge clk) disable iff (!rstN) fillDone |-> !fillBusy)
        else stopOnError($sformatf("FAIL t=%0t fillBusy exp=0 got=%b", $time,
            $sampled(fillBusy)));

    for (genvar s = 0; s < FW; s++) begin : genSlotCheck
        assert property (@(posedge clk) disable iff (!rstN)
            checkOn |-> predTaken[s] == expTaken[s])
            else stopOnError($sformatf("FAIL t=%0t predTaken[%0d] exp=%b got=%b", $time, s,
                $sampled(expTaken[s]), $sampled(predTaken[s])));
        assert property (@(posedge clk) disable iff (!rstN)
            checkOn |-> phtIndex[s] == expIndex[s])
            else stopOnError($sformatf("FAIL t=%0t phtIndex[%0d] exp=%h got=%h", $time, s,
                $sampled(expIndex[s]), $sampled(phtIndex[s])));
        assert property (@(posedge clk) disable iff (!rstN)
            checkOn |-> phtPrevValue[s] == expPrev[s])
            else stopOnError($sformatf("FAIL t=%0t phtPrevValue[%0d] exp=%0d got=%0d", $time, s,
                $sampled(expPrev[s]), $sampled(phtPrevValue[s])));
        assert property (@(posedge clk) disable iff (!rstN)
            checkOn |-> brHistory[s] == expHist[s])
            else stopOnError($sformatf("FAIL t=%0t brHistory[%0d] exp=%b got=%b", $time, s,
                $sampled(expHist[s]), $sampled(brHistory[s])));
    end

    // Idle defaults driven 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
        btbHit = '0;
        isCondBr = '0;
        historyValid = '0;
        resultValid = '0;
        resultIsUncond = '0;
        resultTaken = '0;
        resultMispred = '0;
        recoverHistory = 1'b0;
    endtask

    // Expected outputs for this cycle, then the model steps forward
    task automatic expectOutputs();
        gsharePkg::globalHistoryT hist;
        gsharePkg::phtIndexT idx;
        logic stop;
        hist = modelHist;
        stop = 1'b0;
        for (int i = 0; i < FW; i++) begin
            idx = refModel0.hashIndex(lastPc + (gsharePkg::addrT'(i) << `GS_INSN_OFFSET_BITS),
                modelHist);
            expIndex[i] = idx;
            expPrev[i] = refModel0.counterAt(idx);
            expTaken[i] = btbHit[i] && (expPrev[i][`GS_COUNTER_BITS-1] || !isCondBr[i]);
            if (btbHit[i] && isCondBr[i] && historyValid[i] && !mispredLast && !stop) begin
                hist = refModel0.shiftHistory(hist, expTaken[i]);
            end
            stop = stop || expTaken[i];
            expHist[i] = hist;
        end
        modelHist = recoverHistory ? recoveredHistory : hist;
        mispredLast = |(resultValid & resultMispred);
        lastPc = predPc;
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            nextCycle();
            expectOutputs();
        end
    endtask

    task automatic issueResult(int port, gsharePkg::phtIndexT idx, logic taken);
        resultValid[port] = 1'b1;
        resultTaken[port] = taken;
        resultPhtIndex[port] = idx;
        resultPrevCounter[port] = refModel0.counterAt(idx);
        refModel0.recordResult(idx, taken);
    endtask

    // No BTB hits keeps the history still, so every index is read once
    task automatic sweepTable();
        for (int k = 0; k < TABLE_SIZE / FW; k++) begin
            nextCycle();
            checkOn = 1'b1;
            predPc = gsharePkg::addrT'(k * (FW << `GS_INSN_OFFSET_BITS));
            expectOutputs();
        end
        idleCycles(1);
    endtask

    task automatic randomFetch(int cycles);
        for (int c = 0; c < cycles; c++) begin
            nextCycle();
            checkOn = 1'b1;
            predPc = gsharePkg::addrT'($urandom << `GS_INSN_OFFSET_BITS);
            btbHit = FW'($urandom);
            isCondBr = FW'($urandom);
            historyValid = FW'($urandom);
            // Unconditional mispredicts block the next shift but write nothing
            if ($urandom_range(0, 3) == 0) begin
                resultValid[0] = 1'b1;
                resultIsUncond[0] = 1'b1;
                resultTaken[0] = 1'b1;
                resultMispred[0] = 1'b1;
            end
            if ($urandom_range(0, 7) == 0) begin
                recoverHistory = 1'b1;
                recoveredHistory = gsharePkg::globalHistoryT'($urandom);
            end
            expectOutputs();
        end
    endtask

    task automatic saturateEntry(logic taken);
        gsharePkg::addrT pc;
        gsharePkg::phtIndexT idx;
        pc = gsharePkg::addrT'($urandom << `GS_INSN_OFFSET_BITS);
        idx = refModel0.hashIndex(pc, modelHist);
        for (int n = 0; n < SAT_STEPS; n++) begin
            nextCycle();
            checkOn = 1'b0;
            issueResult(0, idx, taken);
            expectOutputs();
        end
        idleCycles(IDLE_WAIT);
        nextCycle();
        checkOn = 1'b1;
        predPc = pc;
        expectOutputs();
        // Trained entry shows up as a conditional hit on slot 0
        nextCycle();
        btbHit[0] = 1'b1;
        isCondBr[0] = 1'b1;
        historyValid[0] = 1'b1;
        expectOutputs();
    endtask

    // Both ports hit one bank each cycle, so port 1 goes through the queue
    task automatic conflictBurst(int cycles);
        logic used [TABLE_SIZE];
        gsharePkg::phtIndexT idx0;
        gsharePkg::phtIndexT idx1;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            used[i] = 1'b0;
        end
        for (int c = 0; c < cycles; c++) begin
            nextCycle();
            checkOn = 1'b0;
            do begin
                idx0 = gsharePkg::phtIndexT'($urandom);
            end while (used[idx0]);
            used[idx0] = 1'b1;
            do begin
                idx1 = gsharePkg::phtIndexT'($urandom);
                idx1[`GS_BANK_BITS-1:0] = idx0[`GS_BANK_BITS-1:0];
            end while (used[idx1]);
            used[idx1] = 1'b1;
            issueResult(0, idx0, 1'($urandom));
            issueResult(1, idx1, 1'($urandom));
            expectOutputs();
        end
        idleCycles(IDLE_WAIT);
    endtask

    initial begin
        void'($urandom(32'ha477));
        rstN = 1'b0;
        predPc = '0;
        btbHit = '0;
        isCondBr = '0;
        historyValid = '0;
        resultValid = '0;
        resultIsUncond = '0;
        resultTaken = '0;
        resultMispred = '0;
        for (int p = 0; p < IW; p++) begin
            resultPhtIndex[p] = '0;
            resultPrevCounter[p] = '0;
        end
        recoverHistory = 1'b0;
        recoveredHistory = '0;
        checkOn = 1'b0;
        modelHist = '0;
        lastPc = '0;
        mispredLast = 1'b0;

        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        while (fillBusy) begin
            @(posedge clk);
            #1;
        end
        idleCycles(2);

        sweepTable();
        randomFetch(80);
        saturateEntry(1'b0);
        saturateEntry(1'b1);
        conflictBurst(1);
        conflictBurst($urandom_range(2, `GS_QUEUE_DEPTH));
        sweepTable();
        randomFetch(80);
        idleCycles(1);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog/gshareFetchPredict.sv
/*
 * gshare fetch side
 * Keeps the speculative global history, hashes the fetch address into
 * table indices and turns the read counters into slot predictions
 */
`include "gshare_macros.svh"

module gshareFetchPredict (
    input  logic                     clk,
    input  logic                     rstN,
    input  gsharePkg::addrT          predPc,
    input  logic [`GS_FETCH_WIDTH-1:0] btbHit,
    input  logic [`GS_FETCH_WIDTH-1:0] isCondBr,
    input  logic [`GS_FETCH_WIDTH-1:0] historyValid,
    input  gsharePkg::phtCounterT    readCounter [`GS_FETCH_WIDTH],
    input  logic                     mispredSeen,
    input  logic                     recoverHistory,
    input  gsharePkg::globalHistoryT recoveredHistory,
    output gsharePkg::phtIndexT      readIndex [`GS_FETCH_WIDTH],
    output logic [`GS_FETCH_WIDTH-1:0] predTaken,
    output gsharePkg::phtIndexT      phtIndex [`GS_FETCH_WIDTH],
    output gsharePkg::phtCounterT    phtPrevValue [`GS_FETCH_WIDTH],
    output gsharePkg::globalHistoryT brHistory [`GS_FETCH_WIDTH]
);
    gsharePkg::globalHistoryT history;
    gsharePkg::globalHistoryT shiftHistory;
    gsharePkg::globalHistoryT nextHistory;
    gsharePkg::phtIndexT indexQ [`GS_FETCH_WIDTH];
    logic shiftStop;
    logic shiftSlot;

    // Address bits above the offset, history folded in from the top bit down
    function automatic gsharePkg::phtIndexT hashIndex(
        gsharePkg::addrT pc,
        gsharePkg::globalHistoryT hist
    );
        gsharePkg::phtIndexT idx;
        idx = pc[`GS_PHT_INDEX_BITS + `GS_INSN_OFFSET_BITS - 1:`GS_INSN_OFFSET_BITS];
        for (int i = 0; i < `GS_HISTORY_BITS; i++) begin
            idx[`GS_PHT_INDEX_BITS - 1 - i] = idx[`GS_PHT_INDEX_BITS - 1 - i] ^ hist[i];
        end
        return idx;
    endfunction

    always_comb begin
        shiftHistory = history;
        shiftStop = 1'b0;
        shiftSlot = 1'b0;
        for (int i = 0; i < `GS_FETCH_WIDTH; i++) begin
            // Counter MSB, or any unconditional branch the BTB knows
            predTaken[i] = btbHit[i] &&
                (readCounter[i][`GS_COUNTER_BITS-1] || !isCondBr[i]);
            shiftSlot = btbHit[i] && isCondBr[i] && historyValid[i] &&
                !mispredSeen && !shiftStop;
            if (shiftSlot) begin
                shiftHistory = {shiftHistory[`GS_HISTORY_BITS-2:0], predTaken[i]};
            end
            // Slots behind a taken branch are never executed
            if (predTaken[i]) begin
                shiftStop = 1'b1;
            end
            brHistory[i] = shiftHistory;
        end

        nextHistory = recoverHistory ? recoveredHistory : shiftHistory;

        for (int i = 0; i < `GS_FETCH_WIDTH; i++) begin
            readIndex[i] = hashIndex(
                predPc + gsharePkg::addrT'(i << `GS_INSN_OFFSET_BITS),
                nextHistory
            );
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            history <= '0;
        end else begin
            history <= nextHistory;
        end
    end

    // Indices ride alongside the registered table read
    always_ff @(posedge clk) begin
        indexQ <= readIndex;
    end

    assign phtIndex = indexQ;
    assign phtPrevValue = readCounter;

endmodule

//--- verilog/gsharePkg.sv
/*
 * gshare predictor types
 * Typed vectors for addresses, table indices, counters and history,
 * plus the fill sequence state
 */
`include "gshare_macros.svh"

package gsharePkg;

    typedef logic [`GS_ADDR_BITS-1:0] addrT;

    typedef logic [`GS_PHT_INDEX_BITS-1:0] phtIndexT;

    typedef logic [`GS_COUNTER_BITS-1:0] phtCounterT;

    // Bit 0 holds the newest outcome
    typedef logic [`GS_HISTORY_BITS-1:0] globalHistoryT;

    // Low index bits select the bank
    typedef logic [`GS_BANK_BITS-1:0] phtBankT;

    typedef logic [`GS_QUEUE_PTR_BITS-1:0] queuePtrT;

    typedef enum logic {
        FILL_RUN,
        FILL_DONE
    } fillStateT;

endpackage

//--- verilog/gshareUnit.sv
/*
 * gshare direction predictor top level
 * Joins fetch prediction, update arbitration, banked table and write queue
 */
`include "gshare_macros.svh"

module gshareUnit (
    input  logic                     clk,
    input  logic                     rstN,
    // Fetch side
    input  gsharePkg::addrT          predPc,
    input  logic [`GS_FETCH_WIDTH-1:0] btbHit,
    input  logic [`GS_FETCH_WIDTH-1:0] isCondBr,
    input  logic [`GS_FETCH_WIDTH-1:0] historyValid,
    output logic [`GS_FETCH_WIDTH-1:0] predTaken,
    output gsharePkg::phtIndexT      phtIndex [`GS_FETCH_WIDTH],
    output gsharePkg::phtCounterT    phtPrevValue [`GS_FETCH_WIDTH],
    output gsharePkg::globalHistoryT brHistory [`GS_FETCH_WIDTH],
    // Execute side
    input  logic [`GS_ISSUE_WIDTH-1:0] resultValid,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultIsUncond,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultTaken,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultMispred,
    input  gsharePkg::phtIndexT      resultPhtIndex [`GS_ISSUE_WIDTH],
    input  gsharePkg::phtCounterT    resultPrevCounter [`GS_ISSUE_WIDTH],
    input  logic                     recoverHistory,
    input  gsharePkg::globalHistoryT recoveredHistory,
    output logic                     fillBusy
);
    gsharePkg::phtIndexT readIndex [`GS_FETCH_WIDTH];
    gsharePkg::phtCounterT readCounter [`GS_FETCH_WIDTH];
    logic [`GS_ISSUE_WIDTH-1:0] writeEnable;
    gsharePkg::phtIndexT writeIndex [`GS_ISSUE_WIDTH];
    gsharePkg::phtCounterT writeCounter [`GS_ISSUE_WIDTH];
    logic push;
    logic pop;
    gsharePkg::phtIndexT pushIndex;
    gsharePkg::phtCounterT pushCounter;
    gsharePkg::phtIndexT headIndex;
    gsharePkg::phtCounterT headCounter;
    logic empty;
    logic full;
    logic mispredSeen;

    gshareFetchPredict fetchPredict0 (
        .clk, .rstN, .predPc, .btbHit, .isCondBr, .historyValid,
        .readCounter, .mispredSeen, .recoverHistory, .recoveredHistory,
        .readIndex, .predTaken, .phtIndex, .phtPrevValue, .brHistory
    );

    phtUpdateArbiter updateArbiter0 (
        .clk, .rstN, .resultValid, .resultIsUncond, .resultTaken, .resultMispred,
        .resultPhtIndex, .resultPrevCounter, .headIndex, .headCounter, .empty, .full,
        .writeEnable, .writeIndex, .writeCounter, .push, .pushIndex, .pushCounter,
        .pop, .mispredSeen, .fillBusy
    );

    phtBankedRam pht0 (
        .clk, .readIndex, .readCounter, .writeEnable, .writeIndex, .writeCounter
    );

    phtWriteQueue writeQueue0 (
        .clk, .rstN, .push, .pushIndex, .pushCounter, .pop,
        .headIndex, .headCounter, .empty, .full
    );

endmodule

//--- verilog/gshare_macros.svh
/*
 * gshare predictor parameters
 * Widths, table and queue depths and counter constants shared by the RTL
 */
`ifndef GSHARE_MACROS_SVH
`define GSHARE_MACROS_SVH

// Front end and execute widths
`define GS_FETCH_WIDTH 2
`define GS_ISSUE_WIDTH 2

// Address split
`define GS_ADDR_BITS 32
`define GS_INSN_OFFSET_BITS 2

// Table, history and counters
`define GS_PHT_INDEX_BITS 8
`define GS_HISTORY_BITS 6
`define GS_COUNTER_BITS 2
`define GS_COUNTER_MAX ((1 << `GS_COUNTER_BITS) - 1)
`define GS_COUNTER_INIT (`GS_COUNTER_MAX / 2 + 1)

// Banking and deferred write queue
`define GS_BANK_BITS 1
`define GS_QUEUE_DEPTH 4
`define GS_QUEUE_PTR_BITS 2

`endif

//--- verilog/phtBankedRam.sv
/*
 * Banked pattern history table
 * One write port per bank, registered reads for every fetch slot
 */
`include "gshare_macros.svh"

module phtBankedRam (
    input  logic                  clk,
    input  gsharePkg::phtIndexT   readIndex [`GS_FETCH_WIDTH],
    output gsharePkg::phtCounterT readCounter [`GS_FETCH_WIDTH],
    input  logic [`GS_ISSUE_WIDTH-1:0] writeEnable,
    input  gsharePkg::phtIndexT   writeIndex [`GS_ISSUE_WIDTH],
    input  gsharePkg::phtCounterT writeCounter [`GS_ISSUE_WIDTH]
);
    localparam int NUM_BANKS = 1 << `GS_BANK_BITS;
    localparam int ROW_BITS = `GS_PHT_INDEX_BITS - `GS_BANK_BITS;
    localparam int ROWS = 1 << ROW_BITS;

    gsharePkg::phtCounterT bankOut [NUM_BANKS][`GS_FETCH_WIDTH];
    gsharePkg::phtBankT readBankQ [`GS_FETCH_WIDTH];
    logic bankClash;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : genBank
        gsharePkg::phtCounterT mem [ROWS];
        gsharePkg::phtCounterT readQ [`GS_FETCH_WIDTH];
        logic bankWe;
        logic [ROW_BITS-1:0] bankRow;
        gsharePkg::phtCounterT bankData;

        // First enabled port aimed at this bank owns the write port
        always_comb begin
            bankWe = 1'b0;
            bankRow = '0;
            bankData = '0;
            for (int p = `GS_ISSUE_WIDTH - 1; p >= 0; p--) begin
                if (writeEnable[p] && writeIndex[p][`GS_BANK_BITS-1:0] == gsharePkg::phtBankT'(b)) begin
                    bankWe = 1'b1;
                    bankRow = writeIndex[p][`GS_PHT_INDEX_BITS-1:`GS_BANK_BITS];
                    bankData = writeCounter[p];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (bankWe) begin
                mem[bankRow] <= bankData;
            end
            for (int s = 0; s < `GS_FETCH_WIDTH; s++) begin
                readQ[s] <= mem[readIndex[s][`GS_PHT_INDEX_BITS-1:`GS_BANK_BITS]];
            end
        end

        for (genvar s = 0; s < `GS_FETCH_WIDTH; s++) begin : genOut
            assign bankOut[b][s] = readQ[s];
        end
    end

    // Bank select follows the row read by one cycle
    always_ff @(posedge clk) begin
        for (int s = 0; s < `GS_FETCH_WIDTH; s++) begin
            readBankQ[s] <= readIndex[s][`GS_BANK_BITS-1:0];
        end
    end

    always_comb begin
        for (int s = 0; s < `GS_FETCH_WIDTH; s++) begin
            readCounter[s] = bankOut[readBankQ[s]][s];
        end
    end

    always_comb begin
        bankClash = 1'b0;
        for (int p = 1; p < `GS_ISSUE_WIDTH; p++) begin
            for (int q = 0; q < p; q++) begin
                if (writeEnable[p] && writeEnable[q] &&
                    writeIndex[p][`GS_BANK_BITS-1:0] == writeIndex[q][`GS_BANK_BITS-1:0]) begin
                    bankClash = 1'b1;
                end
            end
        end
    end

    // The arbiter has to keep each bank to one write per cycle
    assert property (@(posedge clk) !bankClash)
        else $error("phtBankedRam: two writes to one bank in the same cycle");

endmodule

//--- verilog/phtUpdateArbiter.sv
/*
 * PHT update arbiter
 * Trains counters from execute results, defers bank conflicts to the
 * write queue, drains it into idle ports and runs the reset fill
 */
`include "gshare_macros.svh"

module phtUpdateArbiter (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultValid,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultIsUncond,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultTaken,
    input  logic [`GS_ISSUE_WIDTH-1:0] resultMispred,
    input  gsharePkg::phtIndexT   resultPhtIndex [`GS_ISSUE_WIDTH],
    input  gsharePkg::phtCounterT resultPrevCounter [`GS_ISSUE_WIDTH],
    input  gsharePkg::phtIndexT   headIndex,
    input  gsharePkg::phtCounterT headCounter,
    input  logic                  empty,
    input  logic                  full,
    output logic [`GS_ISSUE_WIDTH-1:0] writeEnable,
    output gsharePkg::phtIndexT   writeIndex [`GS_ISSUE_WIDTH],
    output gsharePkg::phtCounterT writeCounter [`GS_ISSUE_WIDTH],
    output logic                  push,
    output gsharePkg::phtIndexT   pushIndex,
    output gsharePkg::phtCounterT pushCounter,
    output logic                  pop,
    output logic                  mispredSeen,
    output logic                  fillBusy
);
    localparam gsharePkg::phtIndexT FILL_LAST =
        gsharePkg::phtIndexT'((1 << `GS_PHT_INDEX_BITS) - `GS_ISSUE_WIDTH);
    localparam gsharePkg::phtCounterT CNT_MAX = gsharePkg::phtCounterT'(`GS_COUNTER_MAX);

    gsharePkg::fillStateT fillState;
    gsharePkg::phtIndexT fillIndex;
    logic deferReq;
    logic headBlocked;
    logic headPlaced;

    function automatic gsharePkg::phtCounterT saturate(gsharePkg::phtCounterT prev, logic taken);
        if (taken) begin
            return (prev == CNT_MAX) ? CNT_MAX : gsharePkg::phtCounterT'(prev + 1'b1);
        end
        return (prev == '0) ? '0 : gsharePkg::phtCounterT'(prev - 1'b1);
    endfunction

    function automatic logic sameBank(gsharePkg::phtIndexT a, gsharePkg::phtIndexT b);
        gsharePkg::phtBankT bankA;
        gsharePkg::phtBankT bankB;
        bankA = a[`GS_BANK_BITS-1:0];
        bankB = b[`GS_BANK_BITS-1:0];
        return bankA == bankB;
    endfunction

    assign fillBusy = (fillState == gsharePkg::FILL_RUN);

    always_comb begin
        deferReq = 1'b0;
        headBlocked = 1'b0;
        headPlaced = 1'b0;
        pushIndex = '0;
        pushCounter = '0;
        for (int p = 0; p < `GS_ISSUE_WIDTH; p++) begin
            writeEnable[p] = resultValid[p] && !resultIsUncond[p];
            writeIndex[p] = resultPhtIndex[p];
            writeCounter[p] = saturate(resultPrevCounter[p], resultTaken[p]);
        end

        // Later port yields its bank to an earlier write
        for (int p = 1; p < `GS_ISSUE_WIDTH; p++) begin
            for (int q = 0; q < p; q++) begin
                if (writeEnable[p] && writeEnable[q] && sameBank(writeIndex[p], writeIndex[q])) begin
                    writeEnable[p] = 1'b0;
                    deferReq = 1'b1;
                    pushIndex = writeIndex[p];
                    pushCounter = writeCounter[p];
                end
            end
        end
        push = deferReq && !full;

        // Queue head goes out only if its bank is free this cycle
        for (int p = 0; p < `GS_ISSUE_WIDTH; p++) begin
            if (writeEnable[p] && sameBank(writeIndex[p], headIndex)) begin
                headBlocked = 1'b1;
            end
        end
        for (int p = 0; p < `GS_ISSUE_WIDTH; p++) begin
            if (!empty && !headBlocked && !headPlaced && !writeEnable[p]) begin
                writeEnable[p] = 1'b1;
                writeIndex[p] = headIndex;
                writeCounter[p] = headCounter;
                headPlaced = 1'b1;
            end
        end
        pop = headPlaced;

        // Fill owns every port until the table is initialized
        if (fillBusy) begin
            for (int p = 0; p < `GS_ISSUE_WIDTH; p++) begin
                writeEnable[p] = 1'b1;
                writeIndex[p] = gsharePkg::phtIndexT'(fillIndex + p);
                writeCounter[p] = gsharePkg::phtCounterT'(`GS_COUNTER_INIT);
            end
            push = 1'b0;
            pop = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fillState <= gsharePkg::FILL_RUN;
            fillIndex <= '0;
            mispredSeen <= 1'b0;
        end else begin
            mispredSeen <= !fillBusy && |(resultValid & resultMispred);
            if (fillState == gsharePkg::FILL_RUN) begin
                fillIndex <= gsharePkg::phtIndexT'(fillIndex + `GS_ISSUE_WIDTH);
                if (fillIndex == FILL_LAST) begin
                    fillState <= gsharePkg::FILL_DONE;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !(push && full))
        else $error("phtUpdateArbiter: push issued into a full queue");

endmodule

//--- verilog/phtWriteQueue.sv
/*
 * Deferred counter write queue
 * Circular buffer holding table writes that lost a bank conflict
 */
`include "gshare_macros.svh"

module phtWriteQueue (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  push,
    input  gsharePkg::phtIndexT   pushIndex,
    input  gsharePkg::phtCounterT pushCounter,
    input  logic                  pop,
    output gsharePkg::phtIndexT   headIndex,
    output gsharePkg::phtCounterT headCounter,
    output logic                  empty,
    output logic                  full
);
    typedef logic [`GS_QUEUE_PTR_BITS:0] countT;

    gsharePkg::phtIndexT indexMem [`GS_QUEUE_DEPTH];
    gsharePkg::phtCounterT counterMem [`GS_QUEUE_DEPTH];
    gsharePkg::queuePtrT headPtr;
    gsharePkg::queuePtrT tailPtr;
    countT count;
    logic doPush;
    logic doPop;

    assign empty = (count == '0);
    assign full = (count == countT'(`GS_QUEUE_DEPTH));

    // A push into a full queue is lost
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    assign headIndex = indexMem[headPtr];
    assign headCounter = counterMem[headPtr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= gsharePkg::queuePtrT'(tailPtr + 1'b1);
            end
            if (doPop) begin
                headPtr <= gsharePkg::queuePtrT'(headPtr + 1'b1);
            end
            case ({doPush, doPop})
                2'b10: count <= countT'(count + 1'b1);
                2'b01: count <= countT'(count - 1'b1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            indexMem[tailPtr] <= pushIndex;
            counterMem[tailPtr] <= pushCounter;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !(pop && empty))
        else $error("phtWriteQueue: pop while empty");

    assert property (@(posedge clk) disable iff (!rstN) count <= countT'(`GS_QUEUE_DEPTH))
        else $error("phtWriteQueue: occupancy %0d over depth", count);

endmodule
